// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - source/mem_stage_pkg.sv
  - source/mem_req_if.sv
  - source/wb_xfer_if.sv
  - source/store_align.sv
  - source/load_align.sv
  - source/mem_ctrl.sv
  - source/data_sram.sv
  - source/wb_stage.sv
  - source/mem_stage_top.sv
  - target: simulation
    files:
      - dv/mem_stage_checker.sv
      - dv/tb_mem_stage.sv

// ==== all.f ====
source/mem_stage_pkg.sv
source/mem_req_if.sv
source/wb_xfer_if.sv
source/store_align.sv
source/load_align.sv
source/mem_ctrl.sv
source/data_sram.sv
source/wb_stage.sv
source/mem_stage_top.sv
dv/mem_stage_checker.sv
dv/tb_mem_stage.sv

// ==== dv/mem_stage_checker.sv ====
`timescale 1ns/1ps

module mem_stage_checker (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic                                  in_req_i,
    input  logic                                  in_ack_i,
    input  logic                                  out_req_i,
    input  logic [mem_stage_pkg::XLEN-1:0]        out_pc_i,
    input  logic [mem_stage_pkg::XLEN-1:0]        out_inst_i,
    input  logic [mem_stage_pkg::XLEN-1:0]        out_result_i,
    input  logic [mem_stage_pkg::REG_ADDR_W-1:0]  out_rd_i
);

    // Expected records in input order
    logic [mem_stage_pkg::XLEN-1:0]        exp_pc_q[$];
    logic [mem_stage_pkg::XLEN-1:0]        exp_inst_q[$];
    logic [mem_stage_pkg::XLEN-1:0]        exp_result_q[$];
    logic [mem_stage_pkg::REG_ADDR_W-1:0]  exp_rd_q[$];

    int   error_count  = 0;
    int   record_count = 0;
    logic out_req_prev;
    logic req_seen;  // First upstream request has arrived

    function automatic void push_expected(
        input logic [mem_stage_pkg::XLEN-1:0]        pc,
        input logic [mem_stage_pkg::XLEN-1:0]        inst,
        input logic [mem_stage_pkg::XLEN-1:0]        result,
        input logic [mem_stage_pkg::REG_ADDR_W-1:0]  rd
    );
        exp_pc_q.push_back(pc);
        exp_inst_q.push_back(inst);
        exp_result_q.push_back(result);
        exp_rd_q.push_back(rd);
    endfunction

    task automatic compare_field(input int idx, input string field,
                                 input logic [31:0] exp_val, input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("ERROR vector %0d %s: expected 0x%08h, actual 0x%08h",
                     idx, field, exp_val, act_val);
            error_count++;
        end
    endtask

    task automatic check_record();
        if (exp_result_q.size() == 0) begin
            $display("Output record with pc 0x%08h arrived while no instruction was pending",
                     out_pc_i);
            error_count++;
        end else begin
            compare_field(record_count, "pc", exp_pc_q.pop_front(), out_pc_i);
            compare_field(record_count, "inst", exp_inst_q.pop_front(), out_inst_i);
            compare_field(record_count, "result", exp_result_q.pop_front(), out_result_i);
            compare_field(record_count, "rd", 32'(exp_rd_q.pop_front()), 32'(out_rd_i));
        end
        record_count++;
    endtask

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_req_prev <= 1'b0;
            req_seen     <= 1'b0;
        end else begin
            out_req_prev <= out_req_i;
            if (in_req_i) req_seen <= 1'b1;
            // Both handshake outputs stay quiet until the first request
            if (!req_seen && (in_ack_i || out_req_i)) begin
                $display("Handshake output went high after reset before any request");
                error_count++;
            end
            if (out_req_i && !out_req_prev) check_record();  // Rising out_req
        end
    end

endmodule

// ==== dv/mem_stage_stimulus.txt ====
# Columns in hex: pc inst addr rs2 result rd expected_out_result
# Loads expect the aligned memory data, everything else expects its input result
00001000 00002023 00000100 12345678 00000100 00 00000100
00001004 00002003 00000100 00000000 00000100 05 12345678
00001008 00002023 00000104 89abcdef 00000104 00 00000104
0000100c 00002003 00000104 00000000 00000104 06 89abcdef
00001010 00000023 00000101 000000aa 00000101 00 00000101
00001014 00001023 00000106 0000beef 00000106 00 00000106
00001018 00002003 00000100 00000000 00000100 07 1234aa78
0000101c 00002003 00000104 00000000 00000104 08 beefcdef
00001020 00000023 00000103 ffffff80 00000103 00 00000103
00001024 00002003 00000100 00000000 00000100 09 8034aa78
00001028 00000003 00000100 00000000 00000100 0a 00000078
0000102c 00000003 00000101 00000000 00000101 0b ffffffaa
00001030 00000003 00000102 00000000 00000102 0c 00000034
00001034 00000003 00000103 00000000 00000103 0d ffffff80
00001038 00004003 00000100 00000000 00000100 0e 00000078
0000103c 00004003 00000101 00000000 00000101 0f 000000aa
00001040 00004003 00000102 00000000 00000102 10 00000034
00001044 00004003 00000103 00000000 00000103 11 00000080
00001048 00001003 00000100 00000000 00000100 12 ffffaa78
0000104c 00001003 00000102 00000000 00000102 13 ffff8034
00001050 00005003 00000100 00000000 00000100 14 0000aa78
00001054 00005003 00000102 00000000 00000102 15 00008034
00001058 00001003 00000104 00000000 00000104 16 ffffcdef
0000105c 00005003 00000106 00000000 00000106 17 0000beef
00001060 00000003 00000107 00000000 00000107 18 ffffffbe
00001064 00002023 00000108 7fff0001 00000108 00 00000108
00001068 00001003 0000010a 00000000 0000010a 19 00007fff
0000106c 00001003 00000108 00000000 00000108 1a 00000001
00001070 00000013 00000000 00000000 cafef00d 07 cafef00d
00001074 00000033 00000000 00000000 0000002a 1f 0000002a
00001078 00000037 00000000 00000000 abcde000 03 abcde000
0000107c 00002023 000003fc a5a5a5a5 000003fc 00 000003fc
00001080 00002003 000003fc 00000000 000003fc 1b a5a5a5a5
00001084 00000023 000003fc 0000005a 000003fc 00 000003fc
00001088 00004003 000003fc 00000000 000003fc 1c 0000005a

// ==== dv/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 5;
    localparam int DRIVE_DELAY  = 1;
    localparam int SEED         = 48360;

    logic                                  clk;
    logic                                  rst_n_i;
    logic                                  in_req_i;
    logic                                  in_ack_o;
    logic [mem_stage_pkg::XLEN-1:0]        in_pc_i;
    logic [mem_stage_pkg::XLEN-1:0]        in_inst_i;
    logic [mem_stage_pkg::XLEN-1:0]        in_result_i;
    logic [mem_stage_pkg::XLEN-1:0]        in_addr_i;
    logic [mem_stage_pkg::XLEN-1:0]        in_rs2_i;
    logic [mem_stage_pkg::REG_ADDR_W-1:0]  in_rd_i;
    logic                                  out_req_o;
    logic                                  out_ack_i;
    logic [mem_stage_pkg::XLEN-1:0]        out_pc_o;
    logic [mem_stage_pkg::XLEN-1:0]        out_inst_o;
    logic [mem_stage_pkg::XLEN-1:0]        out_result_o;
    logic [mem_stage_pkg::REG_ADDR_W-1:0]  out_rd_o;

    // Vectors from the stimulus file
    logic [mem_stage_pkg::XLEN-1:0]        vec_pc[$];
    logic [mem_stage_pkg::XLEN-1:0]        vec_inst[$];
    logic [mem_stage_pkg::XLEN-1:0]        vec_addr[$];
    logic [mem_stage_pkg::XLEN-1:0]        vec_rs2[$];
    logic [mem_stage_pkg::XLEN-1:0]        vec_result[$];
    logic [mem_stage_pkg::REG_ADDR_W-1:0]  vec_rd[$];
    logic [mem_stage_pkg::XLEN-1:0]        vec_expect[$];

    mem_stage_top dut (.*);

    mem_stage_checker u_checker (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_req_i     (in_req_i),
        .in_ack_i     (in_ack_o),
        .out_req_i    (out_req_o),
        .out_pc_i     (out_pc_o),
        .out_inst_i   (out_inst_o),
        .out_result_i (out_result_o),
        .out_rd_i     (out_rd_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] pc, inst, addr, rs2, result, rd, exp_val;
        fd = $fopen("dv/mem_stage_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/mem_stage_stimulus.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin  // Skip comment lines
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                pc, inst, addr, rs2, result, rd, exp_val);
                    if (n == 7) begin
                        vec_pc.push_back(pc);
                        vec_inst.push_back(inst);
                        vec_addr.push_back(addr);
                        vec_rs2.push_back(rs2);
                        vec_result.push_back(result);
                        vec_rd.push_back(rd[mem_stage_pkg::REG_ADDR_W-1:0]);
                        vec_expect.push_back(exp_val);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One upstream four-phase transfer
    task automatic send_vector(input int idx);
        u_checker.push_expected(vec_pc[idx], vec_inst[idx], vec_expect[idx], vec_rd[idx]);
        in_pc_i     = vec_pc[idx];
        in_inst_i   = vec_inst[idx];
        in_result_i = vec_result[idx];
        in_addr_i   = vec_addr[idx];
        in_rs2_i    = vec_rs2[idx];
        in_rd_i     = vec_rd[idx];
        in_req_i    = 1'b1;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (!in_ack_o);
        in_req_i = 1'b0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (in_ack_o);
    endtask

    // Downstream side with random back-pressure
    task automatic answer_output();
        int unsigned gap;
        forever begin
            do begin
                @(posedge clk);
                #DRIVE_DELAY;
            end while (!out_req_o);
            gap = $urandom % 6;
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            out_ack_i = 1'b1;
            do begin
                @(posedge clk);
                #DRIVE_DELAY;
            end while (out_req_o);
            out_ack_i = 1'b0;
        end
    endtask

    task automatic run_watchdog();
        longint limit_ns;
        limit_ns = (longint'(vec_pc.size()) * 40 + 200) * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout: run did not finish within %0d ns", limit_ns);
        $display("Some tests failed");
        $finish;
    endtask

    initial begin
        void'($urandom(SEED));
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        in_req_i    = 1'b0;
        in_pc_i     = '0;
        in_inst_i   = '0;
        in_result_i = '0;
        in_addr_i   = '0;
        in_rs2_i    = '0;
        in_rd_i     = '0;
        out_ack_i   = 1'b0;
        load_vectors();
        if (vec_pc.size() == 0) begin
            $display("No vectors were read from the stimulus file");
            $display("Some tests failed");
            $finish;
        end else begin
            fork
                run_watchdog();
                answer_output();
            join_none
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            rst_n_i = 1'b1;
            // Quiet stretch so both handshake outputs are seen idle after reset
            repeat (IDLE_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            for (int i = 0; i < vec_pc.size(); i++) begin
                send_vector(i);
            end
            wait (u_checker.record_count >= vec_pc.size());
            wait (!out_req_o && !out_ack_i);  // Last downstream handshake done
            repeat (5) @(posedge clk);  // Catch any stray extra record
            $display("Records checked: %0d of %0d, errors: %0d",
                     u_checker.record_count, vec_pc.size(), u_checker.error_count);
            if (u_checker.error_count == 0 && u_checker.record_count == vec_pc.size()) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

endmodule

// ==== source/data_sram.sv ====
`timescale 1ns/1ps

module data_sram (
    input  logic          clk,
    input  logic          rst_n_i,
    mem_req_if.responder  mem
);

    logic [mem_stage_pkg::XLEN-1:0] ram_q [2**mem_stage_pkg::SRAM_ADDR_W];

    logic [mem_stage_pkg::SRAM_ADDR_W-1:0] word_idx;
    logic [mem_stage_pkg::XLEN-1:0]        rdata_q;
    logic                                  ack_q;
    logic                                  access;

    // Drop the byte offset to get the word index
    assign word_idx = mem.addr[mem_stage_pkg::SRAM_ADDR_W+1:2];

    // One access per new req
    assign access = mem.req && !ack_q;

    always_ff @(posedge clk) begin
        if (access) begin
            if (mem.we) begin
                for (int lane = 0; lane < mem_stage_pkg::LANES; lane++) begin
                    if (mem.wmask[lane]) begin
                        ram_q[word_idx][lane*8 +: 8] <= mem.wdata[lane*8 +: 8];
                    end
                end
            end
            rdata_q <= ram_q[word_idx];  // Old word on a store
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else if (access) begin
            ack_q <= 1'b1;
        end else if (!mem.req) begin
            ack_q <= 1'b0;
        end
    end

    assign mem.ack   = ack_q;
    assign mem.rdata = rdata_q;

    // Requester must hold req until it sees ack
    a_req_held : assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem.req && !mem.ack) |=> mem.req);

endmodule

// ==== source/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  mem_stage_pkg::mem_access_e      access_i,
    input  logic [1:0]                      addr_lo_i,
    input  logic [mem_stage_pkg::XLEN-1:0]  rdata_raw_i,
    output logic [mem_stage_pkg::XLEN-1:0]  rdata_o
);

    logic [mem_stage_pkg::XLEN-1:0] lane;

    // Bring the addressed byte or half down to bit 0
    assign lane = rdata_raw_i >> {addr_lo_i, 3'b000};

    always_comb begin
        unique case (access_i)
            mem_stage_pkg::ACC_B: begin
                rdata_o = {{(mem_stage_pkg::XLEN-8){lane[7]}}, lane[7:0]};
            end
            mem_stage_pkg::ACC_BU: begin
                rdata_o = {{(mem_stage_pkg::XLEN-8){1'b0}}, lane[7:0]};
            end
            mem_stage_pkg::ACC_H: begin
                rdata_o = {{(mem_stage_pkg::XLEN-16){lane[15]}}, lane[15:0]};
            end
            mem_stage_pkg::ACC_HU: begin
                rdata_o = {{(mem_stage_pkg::XLEN-16){1'b0}}, lane[15:0]};
            end
            default: begin
                // Word loads are aligned, no shift needed
                rdata_o = rdata_raw_i;
            end
        endcase
    end

endmodule

// ==== source/mem_ctrl.sv ====
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    // Upstream from execute
    input  logic                                  in_req_i,
    output logic                                  in_ack_o,
    input  logic [mem_stage_pkg::XLEN-1:0]        in_pc_i,
    input  logic [mem_stage_pkg::XLEN-1:0]        in_inst_i,
    input  logic [mem_stage_pkg::XLEN-1:0]        in_result_i,
    input  logic [mem_stage_pkg::XLEN-1:0]        in_addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0]        in_rs2_i,
    input  logic [mem_stage_pkg::REG_ADDR_W-1:0]  in_rd_i,
    // Downstream links
    mem_req_if.requester                          mem,
    wb_xfer_if.requester                          wb
);

    mem_stage_pkg::ctrl_state_e state_q, state_d;

    logic [mem_stage_pkg::XLEN-1:0]        pc_q;
    logic [mem_stage_pkg::XLEN-1:0]        inst_q;
    logic [mem_stage_pkg::XLEN-1:0]        result_q;
    logic [mem_stage_pkg::XLEN-1:0]        addr_q;
    logic [mem_stage_pkg::XLEN-1:0]        rs2_q;
    logic [mem_stage_pkg::REG_ADDR_W-1:0]  rd_q;
    logic [mem_stage_pkg::XLEN-1:0]        rdata_q;

    mem_stage_pkg::opcode_e     opcode;
    mem_stage_pkg::mem_access_e access;
    logic                       is_load;
    logic                       is_store;

    // Decode from the held instruction
    assign opcode   = mem_stage_pkg::opcode_e'(inst_q[6:0]);
    assign access   = mem_stage_pkg::mem_access_e'(inst_q[14:12]);
    assign is_load  = (opcode == mem_stage_pkg::OP_LOAD);
    assign is_store = (opcode == mem_stage_pkg::OP_STORE);

    // Capture the instruction when it is first seen
    always_ff @(posedge clk) begin
        if (state_q == mem_stage_pkg::IDLE && in_req_i) begin
            pc_q     <= in_pc_i;
            inst_q   <= in_inst_i;
            result_q <= in_result_i;
            addr_q   <= in_addr_i;
            rs2_q    <= in_rs2_i;
            rd_q     <= in_rd_i;
        end
        if (state_q == mem_stage_pkg::MEM_REQ && mem.ack) begin
            rdata_q <= mem.rdata;  // rdata only valid with ack
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            mem_stage_pkg::IDLE:
                if (in_req_i) state_d = mem_stage_pkg::ACCEPT;
            mem_stage_pkg::ACCEPT:
                if (!in_req_i) begin
                    // Non-memory instructions go straight to write-back
                    state_d = (is_load || is_store) ? mem_stage_pkg::MEM_REQ
                                                    : mem_stage_pkg::WB_REQ;
                end
            mem_stage_pkg::MEM_REQ:
                if (mem.ack) state_d = mem_stage_pkg::MEM_REL;
            mem_stage_pkg::MEM_REL:
                if (!mem.ack) state_d = mem_stage_pkg::WB_REQ;
            mem_stage_pkg::WB_REQ:
                if (wb.ack) state_d = mem_stage_pkg::WB_REL;  // Stalls here under back-pressure
            mem_stage_pkg::WB_REL:
                if (!wb.ack) state_d = mem_stage_pkg::IDLE;
            default:
                state_d = mem_stage_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= mem_stage_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign in_ack_o = (state_q == mem_stage_pkg::ACCEPT);

    // SRAM request
    assign mem.req  = (state_q == mem_stage_pkg::MEM_REQ);
    assign mem.we   = is_store;
    assign mem.addr = addr_q;

    store_align u_store_align (
        .access_i  (access),
        .addr_lo_i (addr_q[1:0]),
        .rs2_i     (rs2_q),
        .wmask_o   (mem.wmask),
        .wdata_o   (mem.wdata)
    );

    // Record for write-back
    assign wb.req       = (state_q == mem_stage_pkg::WB_REQ);
    assign wb.pc        = pc_q;
    assign wb.inst      = inst_q;
    assign wb.result    = result_q;
    assign wb.rd        = rd_q;
    assign wb.rdata_raw = rdata_q;
    assign wb.access    = access;
    assign wb.addr_lo   = addr_q[1:0];
    assign wb.is_load   = is_load;

    // Misaligned accesses are not trapped, so they must never reach the SRAM
    a_aligned : assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_q == mem_stage_pkg::MEM_REQ) |->
            ((access inside {mem_stage_pkg::ACC_H, mem_stage_pkg::ACC_HU}) -> !addr_q[0]) &&
            ((access == mem_stage_pkg::ACC_W) -> (addr_q[1:0] == 2'b00)));

    a_req_after_ack_low : assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(mem.req) |-> !mem.ack);

endmodule

// ==== source/mem_req_if.sv ====
`timescale 1ns/1ps

// Request/acknowledge link from the access controller to the data SRAM
interface mem_req_if;

    logic                             req;
    logic                             ack;
    logic                             we;     // High for a store
    logic [mem_stage_pkg::XLEN-1:0]   addr;   // Byte address
    logic [mem_stage_pkg::XLEN-1:0]   wdata;  // Already lane shifted
    logic [mem_stage_pkg::LANES-1:0]  wmask;
    logic [mem_stage_pkg::XLEN-1:0]   rdata;  // Valid while ack is high

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        output wmask,
        input  ack,
        input  rdata
    );

    modport responder (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        input  wmask,
        output ack,
        output rdata
    );

endinterface

// ==== source/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // Datapath and address widths
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int SRAM_ADDR_W = 8;  // 256 words of data memory

    // Byte lanes per word
    localparam int LANES       = XLEN / 8;

    // Major opcodes handled by this stage
    // Anything else passes straight to write-back
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    // Access width, encoded exactly as funct3
    typedef enum logic [2:0] {
        ACC_B  = 3'b000,
        ACC_H  = 3'b001,
        ACC_W  = 3'b010,
        ACC_BU = 3'b100,
        ACC_HU = 3'b101
    } mem_access_e;

    // Access controller FSM
    typedef enum logic [2:0] {
        IDLE,     // Waiting for upstream req
        ACCEPT,   // Upstream ack high, wait for req to drop
        MEM_REQ,  // SRAM req high, wait for ack
        MEM_REL,  // SRAM req low, wait for ack to drop
        WB_REQ,   // Write-back req high, wait for ack
        WB_REL    // Write-back req low, wait for ack to drop
    } ctrl_state_e;

endpackage

// ==== source/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    // Upstream handshake and fields
    input  logic                                  in_req_i,
    output logic                                  in_ack_o,
    input  logic [mem_stage_pkg::XLEN-1:0]        in_pc_i,
    input  logic [mem_stage_pkg::XLEN-1:0]        in_inst_i,
    input  logic [mem_stage_pkg::XLEN-1:0]        in_result_i,
    input  logic [mem_stage_pkg::XLEN-1:0]        in_addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0]        in_rs2_i,
    input  logic [mem_stage_pkg::REG_ADDR_W-1:0]  in_rd_i,
    // Downstream handshake and fields
    output logic                                  out_req_o,
    input  logic                                  out_ack_i,
    output logic [mem_stage_pkg::XLEN-1:0]        out_pc_o,
    output logic [mem_stage_pkg::XLEN-1:0]        out_inst_o,
    output logic [mem_stage_pkg::XLEN-1:0]        out_result_o,
    output logic [mem_stage_pkg::REG_ADDR_W-1:0]  out_rd_o
);

    mem_req_if mem_bus ();
    wb_xfer_if wb_bus ();

    mem_ctrl u_mem_ctrl (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_req_i    (in_req_i),
        .in_ack_o    (in_ack_o),
        .in_pc_i     (in_pc_i),
        .in_inst_i   (in_inst_i),
        .in_result_i (in_result_i),
        .in_addr_i   (in_addr_i),
        .in_rs2_i    (in_rs2_i),
        .in_rd_i     (in_rd_i),
        .mem         (mem_bus),
        .wb          (wb_bus)
    );

    data_sram u_data_sram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .mem     (mem_bus)
    );

    // Holds one finished record while the controller works on the next
    wb_stage u_wb_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wb           (wb_bus),
        .out_req_o    (out_req_o),
        .out_ack_i    (out_ack_i),
        .out_pc_o     (out_pc_o),
        .out_inst_o   (out_inst_o),
        .out_result_o (out_result_o),
        .out_rd_o     (out_rd_o)
    );

endmodule

// ==== source/store_align.sv ====
`timescale 1ns/1ps

module store_align (
    input  mem_stage_pkg::mem_access_e          access_i,
    input  logic [1:0]                          addr_lo_i,
    input  logic [mem_stage_pkg::XLEN-1:0]      rs2_i,
    output logic [mem_stage_pkg::LANES-1:0]     wmask_o,
    output logic [mem_stage_pkg::XLEN-1:0]      wdata_o
);

    always_comb begin
        wmask_o = '0;
        wdata_o = rs2_i;
        unique case (access_i)
            mem_stage_pkg::ACC_B,
            mem_stage_pkg::ACC_BU: begin
                // Same byte on every lane, mask picks the one to write
                wdata_o = {4{rs2_i[7:0]}};
                wmask_o = 4'b0001 << addr_lo_i;
            end
            mem_stage_pkg::ACC_H,
            mem_stage_pkg::ACC_HU: begin
                wdata_o = {2{rs2_i[15:0]}};
                wmask_o = 4'b0011 << {addr_lo_i[1], 1'b0};  // Lower or upper half
            end
            mem_stage_pkg::ACC_W: begin
                wdata_o = rs2_i;
                wmask_o = 4'b1111;
            end
            default: begin
                // Reserved funct3 writes nothing
                wmask_o = '0;
            end
        endcase
    end

endmodule

// ==== source/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    wb_xfer_if.responder                          wb,
    output logic                                  out_req_o,
    input  logic                                  out_ack_i,
    output logic [mem_stage_pkg::XLEN-1:0]        out_pc_o,
    output logic [mem_stage_pkg::XLEN-1:0]        out_inst_o,
    output logic [mem_stage_pkg::XLEN-1:0]        out_result_o,
    output logic [mem_stage_pkg::REG_ADDR_W-1:0]  out_rd_o
);

    logic [mem_stage_pkg::XLEN-1:0] load_data;
    logic                           ack_q;
    logic                           full_q;
    logic                           drain_q;  // Output req dropped, waiting on ack low
    logic                           capture;

    load_align u_load_align (
        .access_i    (wb.access),
        .addr_lo_i   (wb.addr_lo),
        .rdata_raw_i (wb.rdata_raw),
        .rdata_o     (load_data)
    );

    assign capture = wb.req && !ack_q && !full_q;

    always_ff @(posedge clk) begin
        if (capture) begin
            out_pc_o     <= wb.pc;
            out_inst_o   <= wb.inst;
            out_result_o <= wb.is_load ? load_data : wb.result;
            out_rd_o     <= wb.rd;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            full_q    <= 1'b0;
            drain_q   <= 1'b0;
            out_req_o <= 1'b0;
        end else begin
            if (capture) begin
                ack_q  <= 1'b1;
                full_q <= 1'b1;
            end else if (ack_q && !wb.req) begin
                ack_q <= 1'b0;
            end
            if (full_q && !out_req_o && !drain_q) begin
                out_req_o <= 1'b1;
            end else if (out_req_o && out_ack_i) begin
                out_req_o <= 1'b0;
                drain_q   <= 1'b1;
            end else if (drain_q && !out_ack_i) begin
                drain_q <= 1'b0;
                full_q  <= 1'b0;  // Slot free for the next record
            end
        end
    end

    assign wb.ack = ack_q;

    a_out_stable : assert property (@(posedge clk) disable iff (!rst_n_i)
        (out_req_o && $past(out_req_o)) |->
            $stable({out_pc_o, out_inst_o, out_result_o, out_rd_o}));

endmodule

// ==== source/wb_xfer_if.sv ====
`timescale 1ns/1ps

// Finished record from the access controller to the write-back stage
interface wb_xfer_if;

    logic                                  req;
    logic                                  ack;
    logic [mem_stage_pkg::XLEN-1:0]        pc;
    logic [mem_stage_pkg::XLEN-1:0]        inst;
    logic [mem_stage_pkg::XLEN-1:0]        result;
    logic [mem_stage_pkg::REG_ADDR_W-1:0]  rd;
    logic [mem_stage_pkg::XLEN-1:0]        rdata_raw;  // Unaligned SRAM word
    mem_stage_pkg::mem_access_e            access;
    logic [1:0]                            addr_lo;    // Byte offset for the load lane
    logic                                  is_load;

    modport requester (
        output req, pc, inst, result, rd, rdata_raw, access, addr_lo, is_load,
        input  ack
    );

    modport responder (
        input  req, pc, inst, result, rd, rdata_raw, access, addr_lo, is_load,
        output ack
    );

endinterface
